// File: rtl/tcdm_pkg.sv
// Widths and opcodes of the TCDM style L2 port
// Only full word accesses are used on this port

package tcdm_pkg;

  // Address and data widths of the L2 port
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Bus words
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Bus opcode
  // The encoding equals the wen level, so a write drives wen low
  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } bus_op_e;

endpackage

// File: rtl/fc_pkg.sv
// Interrupt side constants and types of the fabric controller
// The interrupt id width must cover NUM_EVENTS lines

package fc_pkg;

  // ************************************************************************
  // Interrupt lines
  // ************************************************************************

  // Number of event lines seen by the controller
  localparam int unsigned NUM_EVENTS = 32;

  // Width of an interrupt id, enough to index every event line
  localparam int unsigned IRQ_ID_W = $clog2(NUM_EVENTS);

  // Interrupt id as carried on the acknowledge port
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  // ************************************************************************
  // Service sequencer
  // ************************************************************************

  // States of the interrupt service FSM
  typedef enum logic [2:0] {
    IDLE    = 3'd0,  // waiting for a pending line and fetch enable
    ACK     = 3'd1,  // one cycle acknowledge pulse
    RD_REQ  = 3'd2,  // count read request held until grant
    RD_WAIT = 3'd3,  // waiting for read data
    WR_REQ  = 3'd4,  // count write request held until grant
    WR_WAIT = 3'd5,  // waiting for write response
    HALTED  = 3'd6   // parked by debug request
  } seq_state_e;

endpackage

// File: rtl/fc_event_capture.sv
`timescale 1ns/10ps
// Event capture for the fabric controller interrupt lines
// Events must be slow enough for a two stage register chain in the clk_i domain
// Line LEVEL_EVENT_ID is passed as a level and ignores acknowledge

module fc_event_capture #(
  parameter int unsigned LEVEL_EVENT_ID = 11
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [fc_pkg::NUM_EVENTS-1:0] events_i,
  input  logic                          ack_i,
  input  fc_pkg::irq_id_t               ack_id_i,
  output logic [fc_pkg::NUM_EVENTS-1:0] pending_o
);

  // Register chain over the raw events
  logic [fc_pkg::NUM_EVENTS-1:0] sync_a_q;
  logic [fc_pkg::NUM_EVENTS-1:0] sync_b_q;

  // Later stage one cycle back
  logic [fc_pkg::NUM_EVENTS-1:0] sync_b_prev_q;

  // Rising edge strobes, one cycle wide
  logic [fc_pkg::NUM_EVENTS-1:0] rise;

  // Sticky pending bits
  logic [fc_pkg::NUM_EVENTS-1:0] pending_q;

  // ************************************************************************
  // Edge detection
  // ************************************************************************

  // High for one cycle when the later stage has just gone high
  assign rise = sync_b_q & ~sync_b_prev_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_a_q      <= '0;
      sync_b_q      <= '0;
      sync_b_prev_q <= '0;
    end else begin
      sync_a_q      <= events_i;
      sync_b_q      <= sync_a_q;
      sync_b_prev_q <= sync_b_q;
    end
  end

  // ************************************************************************
  // Pending bits
  // ************************************************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      for (int i = 0; i < fc_pkg::NUM_EVENTS; i++) begin
        if (i == LEVEL_EVENT_ID) begin
          // Event generator line, raw level one cycle late
          pending_q[i] <= events_i[i];
        end else if (ack_i && (ack_id_i == fc_pkg::irq_id_t'(i))) begin
          // Ack has priority over a new edge in the same cycle
          pending_q[i] <= 1'b0;
        end else if (rise[i]) begin
          pending_q[i] <= 1'b1;
        end
      end
    end
  end

  assign pending_o = pending_q;

endmodule

// File: rtl/fc_irq_sequencer.sv
`timescale 1ns/10ps
// Interrupt service sequencer standing in for the fabric controller core
// One L2 access in flight at a time, r_valid must come at least a cycle after gnt
// Count words sit at LOG_BASE + 4 * id and wrap silently on overflow

module fc_irq_sequencer #(
  parameter tcdm_pkg::addr_t LOG_BASE = 32'h1C00_0000
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [fc_pkg::NUM_EVENTS-1:0] pending_i,
  input  logic                          fetch_en_i,
  input  logic                          debug_req_i,
  output logic                          ack_o,
  output fc_pkg::irq_id_t               ack_id_o,
  output logic                          halted_o,
  output logic                          req_o,
  output tcdm_pkg::addr_t               add_o,
  output logic                          wen_o,
  output tcdm_pkg::data_t               wdata_o,
  output logic [3:0]                    be_o,
  input  logic                          gnt_i,
  input  logic                          r_valid_i,
  input  tcdm_pkg::data_t               r_rdata_i
);

  fc_pkg::seq_state_e state_q;
  fc_pkg::seq_state_e state_d;

  // Lowest pending line, from the priority search
  fc_pkg::irq_id_t    pick_id;
  // Id under service, latched when leaving IDLE
  fc_pkg::irq_id_t    id_q;
  // Incremented count waiting to be written back
  tcdm_pkg::data_t    count_q;
  // Current bus opcode
  tcdm_pkg::bus_op_e  bus_op;

  // ************************************************************************
  // Priority search
  // ************************************************************************

  // Scan downward so the lowest set bit is the last one kept
  always_comb begin
    pick_id = '0;
    for (int i = fc_pkg::NUM_EVENTS - 1; i >= 0; i--) begin
      if (pending_i[i]) begin
        pick_id = fc_pkg::irq_id_t'(i);
      end
    end
  end

  // ************************************************************************
  // Service FSM
  // ************************************************************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      fc_pkg::IDLE: begin
        // Debug only takes effect between services
        if (debug_req_i) begin
          state_d = fc_pkg::HALTED;
        end else if (fetch_en_i && (|pending_i)) begin
          state_d = fc_pkg::ACK;
        end
      end
      fc_pkg::ACK:     state_d = fc_pkg::RD_REQ;
      fc_pkg::RD_REQ:  if (gnt_i) state_d = fc_pkg::RD_WAIT;
      fc_pkg::RD_WAIT: if (r_valid_i) state_d = fc_pkg::WR_REQ;
      fc_pkg::WR_REQ:  if (gnt_i) state_d = fc_pkg::WR_WAIT;
      fc_pkg::WR_WAIT: if (r_valid_i) state_d = fc_pkg::IDLE;
      fc_pkg::HALTED:  if (!debug_req_i) state_d = fc_pkg::IDLE;
      default:         state_d = fc_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= fc_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Service payload
  always_ff @(posedge clk_i) begin
    if ((state_q == fc_pkg::IDLE) && (state_d == fc_pkg::ACK)) begin
      id_q <= pick_id;
    end
    if ((state_q == fc_pkg::RD_WAIT) && r_valid_i) begin
      count_q <= r_rdata_i + tcdm_pkg::data_t'(1);
    end
  end

  // ************************************************************************
  // Port side
  // ************************************************************************

  assign ack_o    = (state_q == fc_pkg::ACK);
  assign ack_id_o = id_q;
  assign halted_o = (state_q == fc_pkg::HALTED);

  // Write only while the write request is held
  assign bus_op = (state_q == fc_pkg::WR_REQ) ? tcdm_pkg::OP_WRITE : tcdm_pkg::OP_READ;

  // Request, address and data come from registers and stay stable until gnt
  assign req_o   = (state_q == fc_pkg::RD_REQ) || (state_q == fc_pkg::WR_REQ);
  assign add_o   = LOG_BASE + tcdm_pkg::addr_t'({id_q, 2'b00});
  assign wen_o   = (bus_op == tcdm_pkg::OP_WRITE) ? 1'b0 : 1'b1;
  assign wdata_o = count_q;
  assign be_o    = 4'b1111;

endmodule

// File: rtl/fc_subsystem.sv
`timescale 1ns/10ps
// Fabric controller subsystem with event capture and interrupt sequencer
// Only the L2 data port exists, bus error responses are not supported
// All inputs are taken as synchronous to clk_i except events_i

module fc_subsystem #(
  parameter int unsigned     LEVEL_EVENT_ID = 11,
  parameter tcdm_pkg::addr_t LOG_BASE       = 32'h1C00_0000
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic [fc_pkg::NUM_EVENTS-1:0] events_i,
  input  logic                          fetch_en_i,
  input  logic                          debug_req_i,

  // L2 master port, TCDM style
  output logic                          l2_req_o,
  output tcdm_pkg::addr_t               l2_add_o,
  output logic                          l2_wen_o,
  output tcdm_pkg::data_t               l2_wdata_o,
  output logic [3:0]                    l2_be_o,
  input  logic                          l2_gnt_i,
  input  logic                          l2_r_valid_i,
  input  tcdm_pkg::data_t               l2_r_rdata_i,

  output logic                          core_irq_ack_o,
  output fc_pkg::irq_id_t               core_irq_ack_id_o,
  output logic                          stoptimer_o
);

  // Interrupt path between capture and sequencer
  logic [fc_pkg::NUM_EVENTS-1:0] irq_pending;
  logic                          irq_ack;
  fc_pkg::irq_id_t               irq_ack_id;

  // ************************************************************************
  // Event capture
  // ************************************************************************

  fc_event_capture #(
    .LEVEL_EVENT_ID (LEVEL_EVENT_ID)
  ) u_capture (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .events_i  (events_i),
    .ack_i     (irq_ack),
    .ack_id_i  (irq_ack_id),
    .pending_o (irq_pending)
  );

  // ************************************************************************
  // Interrupt service sequencer
  // ************************************************************************

  fc_irq_sequencer #(
    .LOG_BASE (LOG_BASE)
  ) u_sequencer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pending_i   (irq_pending),
    .fetch_en_i  (fetch_en_i),
    .debug_req_i (debug_req_i),
    .ack_o       (irq_ack),
    .ack_id_o    (irq_ack_id),
    .halted_o    (stoptimer_o),
    .req_o       (l2_req_o),
    .add_o       (l2_add_o),
    .wen_o       (l2_wen_o),
    .wdata_o     (l2_wdata_o),
    .be_o        (l2_be_o),
    .gnt_i       (l2_gnt_i),
    .r_valid_i   (l2_r_valid_i),
    .r_rdata_i   (l2_r_rdata_i)
  );

  // Ack also leaves the subsystem for observation
  assign core_irq_ack_o    = irq_ack;
  assign core_irq_ack_id_o = irq_ack_id;

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/10ps
// Testbench clock with a 20 ns period, reset held low for 10 rising edges

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: test/l2_mem_model.sv
`timescale 1ns/10ps
// Word memory slave for the L2 port, 32 words selected by add_i[6:2]
// Grants come 1 to 4 cycles after req, r_valid one cycle after each grant

module l2_mem_model (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  tcdm_pkg::addr_t add_i,
  input  logic            wen_i,
  input  tcdm_pkg::data_t wdata_i,
  input  logic [3:0]      be_i,
  output logic            gnt_o,
  output logic            r_valid_o,
  output tcdm_pkg::data_t r_rdata_o
);

  tcdm_pkg::data_t words [32];
  tcdm_pkg::data_t wmask;
  logic [15:0]     lfsr_q;
  logic [15:0]     lfsr_1;
  logic [1:0]      stall_q;
  logic            drawn_q;

  // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  assign lfsr_1 = lfsr_step(lfsr_q);
  assign wmask  = {{8{be_i[3]}}, {8{be_i[2]}}, {8{be_i[1]}}, {8{be_i[0]}}};

  // Counts start at zero
  initial begin
    for (int i = 0; i < 32; i++) begin
      words[i] = '0;
    end
  end

  always @(posedge clk_i) begin
    if (gnt_o && !wen_i) begin
      words[add_i[6:2]] <= (words[add_i[6:2]] & ~wmask) | (wdata_i & wmask);
    end
  end

  // ************************************************************************
  // Grant and response
  // ************************************************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_o     <= 1'b0;
      r_valid_o <= 1'b0;
      r_rdata_o <= '0;
      lfsr_q    <= 16'd11;
      stall_q   <= '0;
      drawn_q   <= 1'b0;
    end else begin
      gnt_o     <= 1'b0;
      r_valid_o <= 1'b0;
      if (gnt_o) begin
        // Master takes the grant at this edge
        r_rdata_o <= words[add_i[6:2]];
        r_valid_o <= 1'b1;
        drawn_q   <= 1'b0;
      end else if (req_i && !drawn_q) begin
        // Two stall bits, one LFSR step per bit
        stall_q <= {lfsr_1[0], lfsr_q[0]};
        lfsr_q  <= lfsr_step(lfsr_1);
        drawn_q <= 1'b1;
      end else if (req_i && (stall_q == 2'd0)) begin
        gnt_o <= 1'b1;
      end else if (req_i) begin
        stall_q <= stall_q - 2'd1;
      end
    end
  end

endmodule

// File: test/tb_fc_subsystem.sv
`timescale 1ns/10ps
// Table driven testbench of the fabric controller subsystem
// Count of line 11 is checked for growth and stability, its table nibble is unused

module tb_fc_subsystem;

  localparam int LEVEL_ID = 11;
  localparam int NUM_ROWS = 10;
  localparam int TIMEOUT  = 400;

  // Base address of the count words
  localparam tcdm_pkg::addr_t LOG_BASE = 32'h1C00_0000;

  // Nibble i of exp is the expected count of id i after the row
  typedef struct packed {
    logic [31:0]  pulse;
    logic         level;
    logic         debug;
    logic         fetch;
    logic [127:0] exp;
  } row_t;

  logic                          clk_i;
  logic                          rst_ni;
  logic [fc_pkg::NUM_EVENTS-1:0] events_i;
  logic                          fetch_en_i;
  logic                          debug_req_i;
  logic                          l2_req_o;
  tcdm_pkg::addr_t               l2_add_o;
  logic                          l2_wen_o;
  tcdm_pkg::data_t               l2_wdata_o;
  logic [3:0]                    l2_be_o;
  logic                          l2_gnt_i;
  logic                          l2_r_valid_i;
  tcdm_pkg::data_t               l2_r_rdata_i;
  logic                          core_irq_ack_o;
  fc_pkg::irq_id_t               core_irq_ack_id_o;
  logic                          stoptimer_o;

  row_t            rows [NUM_ROWS];
  fc_pkg::irq_id_t ack_seen [$];
  // Id of the service in progress, taken from the last ack
  fc_pkg::irq_id_t serving_id;
  int              req_cycles;
  int              errors;
  logic            aborted;

  tb_clock_gen u_clk (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  l2_mem_model u_mem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (l2_req_o),
    .add_i     (l2_add_o),
    .wen_i     (l2_wen_o),
    .wdata_i   (l2_wdata_o),
    .be_i      (l2_be_o),
    .gnt_o     (l2_gnt_i),
    .r_valid_o (l2_r_valid_i),
    .r_rdata_o (l2_r_rdata_i)
  );

  fc_subsystem #(
    .LEVEL_EVENT_ID (LEVEL_ID),
    .LOG_BASE       (LOG_BASE)
  ) dut0 (.*);

  // Ack ids other than the level line, and cycles with a bus request
  always @(negedge clk_i) begin
    if (rst_ni && core_irq_ack_o) begin
      serving_id = core_irq_ack_id_o;
    end
    if (rst_ni && core_irq_ack_o && (core_irq_ack_id_o != fc_pkg::irq_id_t'(LEVEL_ID))) begin
      ack_seen.push_back(core_irq_ack_id_o);
    end
    if (rst_ni && l2_req_o) begin
      req_cycles++;
    end
    // Granted access goes to the count word of the acked id, full word
    if (rst_ni && l2_req_o && l2_gnt_i) begin
      check_addr(LOG_BASE + tcdm_pkg::addr_t'(4 * int'(serving_id)), l2_add_o);
      check_be(4'hF, l2_be_o);
    end
  end

  // ************************************************************************
  // Compare tasks
  // ************************************************************************

  task automatic check_count(input int id, input tcdm_pkg::data_t exp);
    tcdm_pkg::data_t got;
    got = u_mem.words[id];
    if (got !== exp) begin
      $display("ERROR l2 count[%0d]: expected %h, got %h", id, exp, got);
      errors++;
    end
  endtask

  task automatic check_addr(input tcdm_pkg::addr_t exp, input tcdm_pkg::addr_t got);
    if (got !== exp) begin
      $display("ERROR l2_add_o: expected %h, got %h", exp, got);
      errors++;
    end
  endtask

  task automatic check_be(input logic [3:0] exp, input logic [3:0] got);
    if (got !== exp) begin
      $display("ERROR l2_be_o: expected %h, got %h", exp, got);
      errors++;
    end
  endtask

  task automatic check_ack_id(input fc_pkg::irq_id_t exp, input fc_pkg::irq_id_t got);
    if (got !== exp) begin
      $display("ERROR core_irq_ack_id_o: expected %h, got %h", exp, got);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("ERROR %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  // Acks must name the expected ids in ascending order
  task automatic compare_acks(input int r, input logic [31:0] expect_mask);
    int k;
    k = 0;
    for (int i = 0; i < fc_pkg::NUM_EVENTS; i++) begin
      if (expect_mask[i]) begin
        if (k < ack_seen.size()) begin
          check_ack_id(fc_pkg::irq_id_t'(i), ack_seen[k]);
        end
        k++;
      end
    end
    if (k != ack_seen.size()) begin
      $display("Row %0d: %0d acks seen where %0d were expected", r, ack_seen.size(), k);
      errors++;
    end
  endtask

  // Idle means no ack and no request for 8 cycles in a row
  task automatic wait_until_idle(input int r);
    int quiet;
    int guard;
    quiet = 0;
    guard = 0;
    while ((quiet < 8) && (guard < TIMEOUT)) begin
      @(negedge clk_i);
      quiet = (core_irq_ack_o || l2_req_o) ? 0 : quiet + 1;
      guard++;
    end
    if (quiet < 8) begin
      $display("Row %0d: the sequencer did not go idle in time", r);
      errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic watch_level_growth(input int r, input tcdm_pkg::data_t start);
    int guard;
    guard = 0;
    while ((u_mem.words[LEVEL_ID] < start + 2) && (guard < TIMEOUT)) begin
      @(negedge clk_i);
      guard++;
    end
    if (u_mem.words[LEVEL_ID] < start + 2) begin
      $display("Row %0d: the level line was not served twice in time", r);
      errors++;
      aborted = 1'b1;
    end
  endtask

  // ************************************************************************
  // Stimulus table and apply loop
  // ************************************************************************

  initial begin
    int              guard;
    int              err_before;
    int              rows_run;
    logic [31:0]     lvl;
    logic [31:0]     held;
    logic            prev_level;
    tcdm_pkg::data_t snap;
    // pulse, level, debug, fetch, expected counts
    rows[0] = '{32'h0000_0008, 1'b0, 1'b0, 1'b1, 128'h0000_0000_0000_0000_0000_0000_0000_1000};
    rows[1] = '{32'h0000_0008, 1'b0, 1'b0, 1'b1, 128'h0000_0000_0000_0000_0000_0000_0000_2000};
    rows[2] = '{32'h0010_0022, 1'b0, 1'b0, 1'b1, 128'h0000_0000_0001_0000_0000_0000_0010_2010};
    rows[3] = '{32'h0000_0000, 1'b1, 1'b0, 1'b1, 128'h0000_0000_0001_0000_0000_0000_0010_2010};
    rows[4] = '{32'h0000_0000, 1'b0, 1'b0, 1'b1, 128'h0000_0000_0001_0000_0000_0000_0010_2010};
    rows[5] = '{32'h0000_0204, 1'b0, 1'b0, 1'b0, 128'h0000_0000_0001_0000_0000_0000_0010_2010};
    rows[6] = '{32'h0000_0000, 1'b0, 1'b0, 1'b1, 128'h0000_0000_0001_0000_0000_0010_0010_2110};
    rows[7] = '{32'h4000_0001, 1'b0, 1'b1, 1'b1, 128'h0000_0000_0001_0000_0000_0010_0010_2110};
    rows[8] = '{32'h0000_0000, 1'b0, 1'b0, 1'b1, 128'h0100_0000_0001_0000_0000_0010_0010_2111};
    rows[9] = '{32'hC000_0008, 1'b0, 1'b0, 1'b1, 128'h1200_0000_0001_0000_0000_0010_0010_3111};
    events_i    = '0;
    fetch_en_i  = 1'b0;
    debug_req_i = 1'b0;
    errors      = 0;
    aborted     = 1'b0;
    req_cycles  = 0;
    rows_run    = 0;
    held        = '0;
    prev_level  = 1'b0;
    guard       = 0;
    while (!rst_ni && (guard < TIMEOUT)) begin
      @(posedge clk_i);
      guard++;
    end
    @(negedge clk_i);
    check_flag("rst_ni", 1'b1, rst_ni);
    check_flag("stoptimer_o", 1'b0, stoptimer_o);
    check_flag("core_irq_ack_o", 1'b0, core_irq_ack_o);
    check_flag("l2_req_o", 1'b0, l2_req_o);
    for (int r = 0; (r < NUM_ROWS) && !aborted; r++) begin
      err_before = errors;
      lvl        = 32'(rows[r].level) << LEVEL_ID;
      held       = held | rows[r].pulse;
      snap       = u_mem.words[LEVEL_ID];
      @(posedge clk_i);
      fetch_en_i  <= rows[r].fetch;
      debug_req_i <= rows[r].debug;
      events_i    <= lvl;
      ack_seen.delete();
      req_cycles = 0;
      repeat (2) @(posedge clk_i);
      if (rows[r].pulse != '0) begin
        events_i <= rows[r].pulse | lvl;
        repeat (2) @(posedge clk_i);
        events_i <= lvl;
      end
      if (rows[r].level) begin
        watch_level_growth(r, snap);
      end else begin
        wait_until_idle(r);
      end
      // Level line must stay put once its last service is over
      if (prev_level && !rows[r].level && !aborted) begin
        // At most the service in flight and one begun in the one cycle lag of line 11
        if (u_mem.words[LEVEL_ID] > snap + 2) begin
          $display("ERROR l2 count[%0d]: expected at most %h, got %h", LEVEL_ID,
                   snap + 2, u_mem.words[LEVEL_ID]);
          errors++;
        end
        snap = u_mem.words[LEVEL_ID];
        repeat (16) @(negedge clk_i);
        check_count(LEVEL_ID, snap);
      end
      @(negedge clk_i);
      check_flag("stoptimer_o", rows[r].debug, stoptimer_o);
      @(posedge clk_i);
      if (!rows[r].fetch || rows[r].debug) begin
        check_flag("l2_req_o seen", 1'b0, req_cycles != 0);
      end
      compare_acks(r, (rows[r].fetch && !rows[r].debug) ? held : 32'h0);
      if (rows[r].fetch && !rows[r].debug) begin
        held = '0;
      end
      for (int i = 0; i < fc_pkg::NUM_EVENTS; i++) begin
        if (i != LEVEL_ID) begin
          check_count(i, tcdm_pkg::data_t'(rows[r].exp[4*i +: 4]));
        end
      end
      prev_level = rows[r].level;
      rows_run++;
      $display("Row %0d %s", r, (errors == err_before) ? "ok" : "with errors");
    end
    $display("Rows run %0d of %0d, errors %0d", rows_run, NUM_ROWS, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: fc_subsystem.f
rtl/tcdm_pkg.sv
rtl/fc_pkg.sv
rtl/fc_event_capture.sv
rtl/fc_irq_sequencer.sv
rtl/fc_subsystem.sv
test/tb_clock_gen.sv
test/l2_mem_model.sv
test/tb_fc_subsystem.sv

// File: Makefile
# Verilator flow for the fabric controller subsystem
# A run fails when the log holds the failure line or no result at all

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/10ps -f fc_subsystem.f \
		--top-module tb_fc_subsystem

run: build
	./obj_dir/Vtb_fc_subsystem | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "Simulation gave no result"; exit 1)

lint:
	verilator --lint-only --timescale 1ns/10ps rtl/tcdm_pkg.sv rtl/fc_pkg.sv \
		rtl/fc_event_capture.sv rtl/fc_irq_sequencer.sv rtl/fc_subsystem.sv \
		--top-module fc_subsystem

clean:
	rm -rf obj_dir $(LOG)
